// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dcache
BUILD_DIR ?= obj_dir
FILE_LIST ?= files.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_bank_ram.sv
rtl/dcache_way_store.sv
rtl/dcache_request_stage.sv
rtl/dcache_lookup_stage.sv
rtl/dcache_miss_unit.sv
rtl/dcache_top.sv
verification/dcache_props.sv
verification/dcache_monitor.sv
verification/tb_dcache.sv

// ==== rtl/dcache_bank_ram.sv ====
`timescale 1ns/1ns

module dcache_bank_ram #(
    parameter int width = 32,
    parameter int depth_bits = 8
) (
    input  logic                  clk,
    input  logic                  wen,
    input  logic [depth_bits-1:0] addr,
    input  logic [width-1:0]      wdata,
    output logic [width-1:0]      rdata
);

    logic [width-1:0] mem [2**depth_bits];

    // read-first: a write in the same cycle returns the old word
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== rtl/dcache_lookup_stage.sv ====
`timescale 1ns/1ns

module dcache_lookup_stage #(
    parameter int index_bits = 8,
    localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits,
    localparam int sel_bits = $clog2(dcache_pkg::words_per_line)
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             buf_valid,
    input  dcache_pkg::cpu_op_t              buf_op,
    input  logic [tag_bits-1:0]              buf_tag,
    input  logic [sel_bits-1:0]              buf_word_sel,
    input  logic [dcache_pkg::word_bits-1:0] buf_wdata,
    input  logic [tag_bits-1:0]              way0_tag,
    input  logic                             way0_valid,
    input  logic [dcache_pkg::line_bits-1:0] way0_line,
    input  logic [tag_bits-1:0]              way1_tag,
    input  logic                             way1_valid,
    input  logic [dcache_pkg::line_bits-1:0] way1_line,
    input  logic                             fill_done,
    input  logic [dcache_pkg::word_bits-1:0] fill_word,
    output logic                             lookup_miss,
    output logic                             store_hit_stall,
    output logic                             hit_wen0,
    output logic                             hit_wen1,
    output logic [sel_bits-1:0]              hit_word_sel,
    output logic [dcache_pkg::word_bits-1:0] hit_wdata,
    output logic                             data_ok,
    output logic [dcache_pkg::word_bits-1:0] rdata
);

    import dcache_pkg::*;

    logic [1:0] hit_way;
    logic hit;
    logic [line_bits-1:0] hit_line;
    logic [word_bits-1:0] hit_word;

    assign hit_way[0] = buf_valid && way0_valid && (way0_tag == buf_tag);
    assign hit_way[1] = buf_valid && way1_valid && (way1_tag == buf_tag);
    assign hit = |hit_way;

    assign lookup_miss = buf_valid && !hit;
    assign store_hit_stall = hit && (buf_op == op_store);

    // store hit goes straight into the bank this cycle
    assign hit_wen0 = store_hit_stall && hit_way[0];
    assign hit_wen1 = store_hit_stall && hit_way[1];
    assign hit_word_sel = buf_word_sel;
    assign hit_wdata = buf_wdata;

    assign hit_line = hit_way[1] ? way1_line : way0_line;
    assign hit_word = hit_line[buf_word_sel*word_bits +: word_bits];

    // response register, fed by a hit or by a finished refill
    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= hit || fill_done;
        end
    end

    always_ff @(posedge clk) begin
        if (hit || fill_done) begin
            rdata <= fill_done ? fill_word : hit_word;
        end
    end

endmodule

// ==== rtl/dcache_miss_unit.sv ====
`timescale 1ns/1ns

module dcache_miss_unit #(
    parameter int index_bits = 8,
    localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits,
    localparam int sel_bits = $clog2(dcache_pkg::words_per_line)
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             lookup_miss,
    input  dcache_pkg::cpu_op_t              buf_op,
    input  logic [tag_bits-1:0]              buf_tag,
    input  logic [index_bits-1:0]            buf_index,
    input  logic [sel_bits-1:0]              buf_word_sel,
    input  logic [dcache_pkg::word_bits-1:0] buf_wdata,
    input  logic [tag_bits-1:0]              way0_tag,
    input  logic                             way0_valid,
    input  logic                             way0_dirty,
    input  logic [dcache_pkg::line_bits-1:0] way0_line,
    input  logic [tag_bits-1:0]              way1_tag,
    input  logic                             way1_valid,
    input  logic                             way1_dirty,
    input  logic [dcache_pkg::line_bits-1:0] way1_line,
    input  logic                             rd_rdy,
    input  logic                             ret_valid,
    input  logic [dcache_pkg::line_bits-1:0] ret_data,
    input  logic                             wr_rdy,
    output logic                             miss_busy,
    output logic                             rd_req,
    output logic [dcache_pkg::addr_bits-1:0] rd_addr,
    output logic                             wr_req,
    output logic [dcache_pkg::addr_bits-1:0] wr_addr,
    output logic [dcache_pkg::line_bits-1:0] wr_data,
    output logic                             fill_wen0,
    output logic                             fill_wen1,
    output logic [dcache_pkg::line_bits-1:0] fill_line,
    output logic [tag_bits-1:0]              fill_tag,
    output logic                             fill_dirty,
    output logic                             fill_done,
    output logic [dcache_pkg::word_bits-1:0] fill_word
);

    import dcache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;
    logic [2**index_bits-1:0] rr_q;
    logic victim;
    logic victim_dirty;
    logic victim_q;
    logic [tag_bits-1:0] victim_tag;

    // an empty way wins over the round-robin pick
    assign victim = !way0_valid ? 1'b0 : (!way1_valid ? 1'b1 : rr_q[buf_index]);
    assign victim_dirty = victim ? way1_dirty : way0_dirty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ms_idle: begin
                if (lookup_miss) begin
                    state_d = victim_dirty ? ms_write_back : ms_refill_req;
                end
            end
            ms_write_back: begin
                if (wr_rdy) begin
                    state_d = ms_refill_req;
                end
            end
            ms_refill_req: begin
                if (rd_rdy) begin
                    state_d = ms_refill_wait;
                end
            end
            ms_refill_wait: begin
                if (ret_valid) begin
                    state_d = ms_respond;
                end
            end
            default: state_d = ms_idle;
        endcase
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state_q <= ms_idle;
            victim_q <= 1'b0;
            rr_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ms_idle && lookup_miss) begin
                victim_q <= victim;
            end
            if (fill_done) begin
                rr_q[buf_index] <= ~rr_q[buf_index];
            end
        end
    end

    assign miss_busy = state_q != ms_idle;

    // victim line stays on the ram output since the set is not rewritten yet
    assign victim_tag = victim_q ? way1_tag : way0_tag;
    assign wr_req = state_q == ms_write_back;
    assign wr_addr = {victim_tag, buf_index, {offset_bits{1'b0}}};
    assign wr_data = victim_q ? way1_line : way0_line;

    assign rd_req = state_q == ms_refill_req;
    assign rd_addr = {buf_tag, buf_index, {offset_bits{1'b0}}};

    // store miss merges its word into the returned line
    always_comb begin
        fill_line = ret_data;
        if (buf_op == op_store) begin
            fill_line[buf_word_sel*word_bits +: word_bits] = buf_wdata;
        end
    end

    assign fill_done = (state_q == ms_refill_wait) && ret_valid;
    assign fill_wen0 = fill_done && !victim_q;
    assign fill_wen1 = fill_done && victim_q;
    assign fill_tag = buf_tag;
    assign fill_dirty = buf_op == op_store;
    assign fill_word = fill_line[buf_word_sel*word_bits +: word_bits];

endmodule

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    // line geometry
    localparam int offset_bits = 4;
    localparam int word_bits = 32;
    localparam int line_bits = 128;
    localparam int words_per_line = 4;

    // cpu address width
    localparam int addr_bits = 32;

    typedef enum logic {
        op_load,
        op_store
    } cpu_op_t;

    // miss handling sequence
    typedef enum logic [2:0] {
        ms_idle,
        ms_write_back,
        ms_refill_req,
        ms_refill_wait,
        ms_respond
    } miss_state_t;

endpackage

// ==== rtl/dcache_request_stage.sv ====
`timescale 1ns/1ns

module dcache_request_stage #(
    parameter int index_bits = 8,
    localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits,
    localparam int sel_bits = $clog2(dcache_pkg::words_per_line)
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               valid,
    input  dcache_pkg::cpu_op_t                op,
    input  logic [tag_bits-1:0]                tag,
    input  logic [index_bits-1:0]              index,
    input  logic [dcache_pkg::offset_bits-1:0] offset,
    input  logic [dcache_pkg::word_bits-1:0]   wdata,
    input  logic                               lookup_miss,
    input  logic                               store_hit_stall,
    input  logic                               miss_busy,
    output logic                               addr_ok,
    output logic [index_bits-1:0]              ram_index,
    output logic                               buf_valid,
    output dcache_pkg::cpu_op_t                buf_op,
    output logic [tag_bits-1:0]                buf_tag,
    output logic [index_bits-1:0]              buf_index,
    output logic [sel_bits-1:0]                buf_word_sel,
    output logic [dcache_pkg::word_bits-1:0]   buf_wdata
);

    import dcache_pkg::*;

    logic accept;

    assign addr_ok = !miss_busy && !lookup_miss && !store_hit_stall;
    assign accept = valid && addr_ok;

    // read the new set on accept, otherwise keep re-reading the buffered one
    assign ram_index = accept ? index : buf_index;

    // a miss holds the slot only until the miss unit takes over;
    // the payload stays put since nothing is accepted while busy
    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            buf_valid <= 1'b1;
        end else if (!(lookup_miss && !miss_busy)) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_op <= op;
            buf_tag <= tag;
            buf_index <= index;
            buf_word_sel <= offset[offset_bits-1 -: sel_bits];
            buf_wdata <= wdata;
        end
    end

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
    parameter int index_bits = 8,
    localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               valid,
    input  dcache_pkg::cpu_op_t                op,
    input  logic [tag_bits-1:0]                tag,
    input  logic [index_bits-1:0]              index,
    input  logic [dcache_pkg::offset_bits-1:0] offset,
    input  logic [dcache_pkg::word_bits-1:0]   wdata,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [dcache_pkg::word_bits-1:0]   rdata,
    output logic                               rd_req,
    output logic [dcache_pkg::addr_bits-1:0]   rd_addr,
    input  logic                               rd_rdy,
    input  logic                               ret_valid,
    input  logic [dcache_pkg::line_bits-1:0]   ret_data,
    output logic                               wr_req,
    output logic [dcache_pkg::addr_bits-1:0]   wr_addr,
    output logic [dcache_pkg::line_bits-1:0]   wr_data,
    input  logic                               wr_rdy
);

    import dcache_pkg::*;

    localparam int sel_bits = $clog2(words_per_line);

    logic [index_bits-1:0] ram_index;
    logic buf_valid;
    cpu_op_t buf_op;
    logic [tag_bits-1:0] buf_tag;
    logic [index_bits-1:0] buf_index;
    logic [sel_bits-1:0] buf_word_sel;
    logic [word_bits-1:0] buf_wdata;
    logic lookup_miss;
    logic store_hit_stall;
    logic miss_busy;
    logic hit_wen0;
    logic hit_wen1;
    logic [sel_bits-1:0] hit_word_sel;
    logic [word_bits-1:0] hit_wdata;
    logic fill_wen0;
    logic fill_wen1;
    logic [line_bits-1:0] fill_line;
    logic [tag_bits-1:0] fill_tag;
    logic fill_dirty;
    logic fill_done;
    logic [word_bits-1:0] fill_word;
    logic [tag_bits-1:0] way0_tag;
    logic [tag_bits-1:0] way1_tag;
    logic way0_valid;
    logic way1_valid;
    logic way0_dirty;
    logic way1_dirty;
    logic [line_bits-1:0] way0_line;
    logic [line_bits-1:0] way1_line;

    dcache_request_stage #(.index_bits(index_bits)) req_i (
        .clk            (clk),
        .resetn         (resetn),
        .valid          (valid),
        .op             (op),
        .tag            (tag),
        .index          (index),
        .offset         (offset),
        .wdata          (wdata),
        .lookup_miss    (lookup_miss),
        .store_hit_stall(store_hit_stall),
        .miss_busy      (miss_busy),
        .addr_ok        (addr_ok),
        .ram_index      (ram_index),
        .buf_valid      (buf_valid),
        .buf_op         (buf_op),
        .buf_tag        (buf_tag),
        .buf_index      (buf_index),
        .buf_word_sel   (buf_word_sel),
        .buf_wdata      (buf_wdata)
    );

    dcache_lookup_stage #(.index_bits(index_bits)) lookup_i (
        .clk            (clk),
        .resetn         (resetn),
        .buf_valid      (buf_valid),
        .buf_op         (buf_op),
        .buf_tag        (buf_tag),
        .buf_word_sel   (buf_word_sel),
        .buf_wdata      (buf_wdata),
        .way0_tag       (way0_tag),
        .way0_valid     (way0_valid),
        .way0_line      (way0_line),
        .way1_tag       (way1_tag),
        .way1_valid     (way1_valid),
        .way1_line      (way1_line),
        .fill_done      (fill_done),
        .fill_word      (fill_word),
        .lookup_miss    (lookup_miss),
        .store_hit_stall(store_hit_stall),
        .hit_wen0       (hit_wen0),
        .hit_wen1       (hit_wen1),
        .hit_word_sel   (hit_word_sel),
        .hit_wdata      (hit_wdata),
        .data_ok        (data_ok),
        .rdata          (rdata)
    );

    dcache_miss_unit #(.index_bits(index_bits)) miss_i (
        .clk         (clk),
        .resetn      (resetn),
        .lookup_miss (lookup_miss),
        .buf_op      (buf_op),
        .buf_tag     (buf_tag),
        .buf_index   (buf_index),
        .buf_word_sel(buf_word_sel),
        .buf_wdata   (buf_wdata),
        .way0_tag    (way0_tag),
        .way0_valid  (way0_valid),
        .way0_dirty  (way0_dirty),
        .way0_line   (way0_line),
        .way1_tag    (way1_tag),
        .way1_valid  (way1_valid),
        .way1_dirty  (way1_dirty),
        .way1_line   (way1_line),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .wr_rdy      (wr_rdy),
        .miss_busy   (miss_busy),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .fill_wen0   (fill_wen0),
        .fill_wen1   (fill_wen1),
        .fill_line   (fill_line),
        .fill_tag    (fill_tag),
        .fill_dirty  (fill_dirty),
        .fill_done   (fill_done),
        .fill_word   (fill_word)
    );

    dcache_way_store #(.index_bits(index_bits)) way0_i (
        .clk         (clk),
        .resetn      (resetn),
        .ram_index   (ram_index),
        .hit_wen     (hit_wen0),
        .hit_word_sel(hit_word_sel),
        .hit_wdata   (hit_wdata),
        .fill_wen    (fill_wen0),
        .fill_line   (fill_line),
        .fill_tag    (fill_tag),
        .fill_dirty  (fill_dirty),
        .way_tag     (way0_tag),
        .way_valid   (way0_valid),
        .way_dirty   (way0_dirty),
        .way_line    (way0_line)
    );

    dcache_way_store #(.index_bits(index_bits)) way1_i (
        .clk         (clk),
        .resetn      (resetn),
        .ram_index   (ram_index),
        .hit_wen     (hit_wen1),
        .hit_word_sel(hit_word_sel),
        .hit_wdata   (hit_wdata),
        .fill_wen    (fill_wen1),
        .fill_line   (fill_line),
        .fill_tag    (fill_tag),
        .fill_dirty  (fill_dirty),
        .way_tag     (way1_tag),
        .way_valid   (way1_valid),
        .way_dirty   (way1_dirty),
        .way_line    (way1_line)
    );

endmodule

// ==== rtl/dcache_way_store.sv ====
`timescale 1ns/1ns

module dcache_way_store #(
    parameter int index_bits = 8,
    localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits,
    localparam int sel_bits = $clog2(dcache_pkg::words_per_line)
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [index_bits-1:0]           ram_index,
    input  logic                            hit_wen,
    input  logic [sel_bits-1:0]             hit_word_sel,
    input  logic [dcache_pkg::word_bits-1:0] hit_wdata,
    input  logic                            fill_wen,
    input  logic [dcache_pkg::line_bits-1:0] fill_line,
    input  logic [tag_bits-1:0]             fill_tag,
    input  logic                            fill_dirty,
    output logic [tag_bits-1:0]             way_tag,
    output logic                            way_valid,
    output logic                            way_dirty,
    output logic [dcache_pkg::line_bits-1:0] way_line
);

    import dcache_pkg::*;

    logic [2**index_bits-1:0] valid_q;
    logic [2**index_bits-1:0] dirty_q;

    dcache_bank_ram #(
        .width     (tag_bits),
        .depth_bits(index_bits)
    ) tag_ram_i (
        .clk  (clk),
        .wen  (fill_wen),
        .addr (ram_index),
        .wdata(fill_tag),
        .rdata(way_tag)
    );

    // one bank per word, refill writes all of them
    for (genvar k = 0; k < words_per_line; k++) begin : g_bank
        dcache_bank_ram #(
            .width     (word_bits),
            .depth_bits(index_bits)
        ) bank_i (
            .clk  (clk),
            .wen  (fill_wen || (hit_wen && hit_word_sel == sel_bits'(k))),
            .addr (ram_index),
            .wdata(fill_wen ? fill_line[k*word_bits +: word_bits] : hit_wdata),
            .rdata(way_line[k*word_bits +: word_bits])
        );
    end

    // flag read is registered so it lines up with the ram output
    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            way_valid <= 1'b0;
            way_dirty <= 1'b0;
        end else begin
            way_valid <= valid_q[ram_index];
            way_dirty <= dirty_q[ram_index];
            if (fill_wen) begin
                valid_q[ram_index] <= 1'b1;
                dirty_q[ram_index] <= fill_dirty;
            end else if (hit_wen) begin
                dirty_q[ram_index] <= 1'b1;
            end
        end
    end

endmodule

// ==== include/mem_pattern.svh ====
// fill pattern of a never-written backing word mixed from its whole address
function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a0f_c3e1;
endfunction

// ==== verification/dcache_monitor.sv ====
`timescale 1ns/1ns

module dcache_monitor #(
    parameter int index_bits = 8,
    localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               valid,
    input  dcache_pkg::cpu_op_t                op,
    input  logic [tag_bits-1:0]                tag,
    input  logic [index_bits-1:0]              index,
    input  logic [dcache_pkg::offset_bits-1:0] offset,
    input  logic [dcache_pkg::word_bits-1:0]   wdata,
    input  logic                               addr_ok,
    input  logic                               data_ok,
    input  logic [dcache_pkg::word_bits-1:0]   rdata,
    input  logic                               rd_req,
    input  logic [31:0]                        rd_addr,
    input  logic                               rd_rdy,
    input  logic                               wr_req,
    input  logic [31:0]                        wr_addr,
    input  logic [127:0]                       wr_data,
    input  logic                               wr_rdy,
    output int                                 error_count,
    output int                                 outstanding,
    output int                                 writebacks
);

    import dcache_pkg::*;

    `include "mem_pattern.svh"

    logic [31:0] model [logic [29:0]];
    bit dirty_lines [logic [27:0]];
    // most recent refill per set stays resident until the next refill there
    logic [27:0] last_fill [logic [index_bits-1:0]];
    logic [31:0] exp_data_q [$];
    bit exp_load_q [$];
    bit exp_fast_q [$];
    int exp_cycle_q [$];
    int cycle = 0;
    bit after_reset = 1'b1;
    bit rd_wait = 1'b0;
    bit wr_wait = 1'b0;
    logic [31:0] rd_addr_q;
    logic [31:0] wr_addr_q;
    logic [127:0] wr_data_q;
    // any refill belongs to the newest accepted request
    logic [27:0] req_line;

    initial begin
        error_count = 0;
        outstanding = 0;
        writebacks = 0;
    end

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        if (model.exists(addr[31:2])) begin
            return model[addr[31:2]];
        end
        return pattern_word({addr[31:2], 2'b00});
    endfunction

    task automatic verify_reset_state();
        if (!addr_ok || data_ok || rd_req || wr_req) begin
            error_count++;
            $display("FAIL reset_state expected %b actual %b", 4'b1000,
                {addr_ok, data_ok, rd_req, wr_req});
        end
    endtask

    task automatic track_handshake();
        if (rd_req && wr_req) begin
            error_count++;
            $display("rd_req and wr_req were high together at cycle %0d", cycle);
        end
        if (rd_wait && (!rd_req || rd_addr != rd_addr_q)) begin
            error_count++;
            $display("read request was withdrawn before rd_rdy at cycle %0d", cycle);
        end
        if (wr_wait && (!wr_req || wr_addr != wr_addr_q || wr_data != wr_data_q)) begin
            error_count++;
            $display("write request was withdrawn before wr_rdy at cycle %0d", cycle);
        end
        rd_wait = rd_req && !rd_rdy;
        wr_wait = wr_req && !wr_rdy;
        rd_addr_q = rd_addr;
        wr_addr_q = wr_addr;
        wr_data_q = wr_data;
    endtask

    task automatic check_write_back();
        logic [31:0] exp_word;
        writebacks++;
        for (int k = 0; k < 4; k++) begin
            exp_word = model_word(wr_addr + 32'(4 * k));
            if (wr_data[k*32 +: 32] != exp_word) begin
                error_count++;
                $display("FAIL write_back expected %h actual %h", exp_word, wr_data[k*32 +: 32]);
            end
        end
        if (!dirty_lines.exists(wr_addr[31:4])) begin
            error_count++;
            $display("line %h was written back without a pending store", wr_addr);
        end else begin
            dirty_lines.delete(wr_addr[31:4]);
        end
    endtask

    task automatic match_response();
        int latency;
        if (exp_load_q.size() == 0) begin
            error_count++;
            $display("data_ok arrived with no request outstanding at cycle %0d", cycle);
        end else begin
            latency = cycle - exp_cycle_q[0];
            if (exp_load_q[0] && rdata != exp_data_q[0]) begin
                error_count++;
                $display("FAIL load_data expected %h actual %h", exp_data_q[0], rdata);
            end
            if (exp_fast_q[0] && latency != 2) begin
                error_count++;
                $display("FAIL hit_latency expected %0d actual %0d", 2, latency);
            end
            void'(exp_load_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_fast_q.pop_front());
            void'(exp_cycle_q.pop_front());
        end
    endtask

    task automatic record_request();
        logic [31:0] addr;
        addr = {tag, index, offset};
        req_line = addr[31:4];
        exp_load_q.push_back(op == op_load);
        exp_cycle_q.push_back(cycle);
        exp_fast_q.push_back(op == op_load && last_fill.exists(index)
            && last_fill[index] == addr[31:4]);
        if (op == op_store) begin
            model[addr[31:2]] = wdata;
            dirty_lines[addr[31:4]] = 1'b1;
            exp_data_q.push_back(32'h0);
        end else begin
            exp_data_q.push_back(model_word(addr));
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            verify_reset_state();
        end else begin
            if (after_reset) begin
                verify_reset_state();
                after_reset = 1'b0;
            end
            cycle++;
            track_handshake();
            if (wr_req && wr_rdy) begin
                check_write_back();
            end
            if (rd_req && rd_rdy) begin
                if (rd_addr != {req_line, 4'h0}) begin
                    error_count++;
                    $display("FAIL refill_addr expected %h actual %h", {req_line, 4'h0}, rd_addr);
                end
                last_fill[rd_addr[index_bits+3:4]] = rd_addr[31:4];
            end
            if (data_ok) begin
                match_response();
            end
            if (valid && addr_ok) begin
                record_request();
            end
        end
        outstanding = exp_load_q.size();
    end

endmodule

// ==== verification/dcache_props.sv ====
`timescale 1ns/1ns

module dcache_props (
    input logic         clk,
    input logic         resetn,
    input logic         rd_req,
    input logic         rd_rdy,
    input logic [31:0]  rd_addr,
    input logic         wr_req,
    input logic         wr_rdy,
    input logic [31:0]  wr_addr,
    input logic [127:0] wr_data
);

    // only one memory request at a time
    req_exclusive: assert property (@(posedge clk) disable iff (resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high in the same cycle");

    rd_req_held: assert property (@(posedge clk) disable iff (resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else $error("rd_req dropped or rd_addr changed before rd_rdy");

    wr_req_held: assert property (@(posedge clk) disable iff (resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else $error("wr_req dropped or write payload changed before wr_rdy");

endmodule

bind dcache_top dcache_props props_i (
    .clk    (clk),
    .resetn (resetn),
    .rd_req (rd_req),
    .rd_rdy (rd_rdy),
    .rd_addr(rd_addr),
    .wr_req (wr_req),
    .wr_rdy (wr_rdy),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
);

// ==== verification/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;

    import dcache_pkg::*;

    `include "mem_pattern.svh"

    localparam int index_bits = 8;
    localparam int tag_bits = addr_bits - index_bits - offset_bits;
    localparam int num_requests = 3000;
    localparam int wait_limit = 200;

    // small pool so that sets overflow their two ways
    localparam logic [tag_bits-1:0] tag_pool [4] = '{20'h0_0a1c, 20'h3_5f20, 20'h8_00e7, 20'hf_c413};
    localparam logic [index_bits-1:0] index_pool [4] = '{8'h00, 8'h01, 8'h7e, 8'hc5};

    logic clk = 1'b0;
    logic resetn;
    logic valid;
    cpu_op_t op;
    logic [tag_bits-1:0] tag;
    logic [index_bits-1:0] index;
    logic [offset_bits-1:0] offset;
    logic [word_bits-1:0] wdata;
    logic addr_ok;
    logic data_ok;
    logic [word_bits-1:0] rdata;
    logic rd_req;
    logic [addr_bits-1:0] rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic [line_bits-1:0] ret_data;
    logic wr_req;
    logic [addr_bits-1:0] wr_addr;
    logic [line_bits-1:0] wr_data;
    logic wr_rdy;
    int error_count;
    int outstanding;
    int writebacks;

    logic [line_bits-1:0] backing [logic [27:0]];
    bit rd_pending = 1'b0;
    logic [27:0] rd_line;
    int rd_delay;
    bit timed_out = 1'b0;

    always #2 clk = ~clk;

    dcache_top #(.index_bits(index_bits)) dut_i (.*);

    dcache_monitor #(.index_bits(index_bits)) mon_i (.*);

    function automatic logic [line_bits-1:0] read_line(input logic [27:0] line);
        logic [line_bits-1:0] data;
        if (backing.exists(line)) begin
            return backing[line];
        end
        for (int k = 0; k < 4; k++) begin
            data[k*32 +: 32] = pattern_word({line, 2'(k), 2'b00});
        end
        return data;
    endfunction

    // memory side takes transfers at the rising edge
    always @(posedge clk) begin
        if (!resetn) begin
            if (wr_req && wr_rdy) begin
                backing[wr_addr[31:4]] = wr_data;
            end
            if (rd_req && rd_rdy) begin
                rd_pending = 1'b1;
                rd_line = rd_addr[31:4];
                rd_delay = $urandom_range(0, 5);
            end
        end
    end

    always @(negedge clk) begin
        rd_rdy = ($urandom % 3) != 0;
        wr_rdy = ($urandom % 3) != 0;
        ret_valid = 1'b0;
        if (rd_pending) begin
            if (rd_delay == 0) begin
                ret_valid = 1'b1;
                ret_data = read_line(rd_line);
                rd_pending = 1'b0;
            end else begin
                rd_delay--;
            end
        end
    end

    task automatic send_request();
        int waited;
        valid = 1'b1;
        op = ($urandom % 2) ? op_store : op_load;
        tag = tag_pool[$urandom % 4];
        index = index_pool[$urandom % 4];
        offset = {2'($urandom % 4), 2'b00};
        wdata = $urandom;
        waited = 0;
        while (!addr_ok && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                timed_out = 1'b1;
                $display("cache never raised addr_ok for a pending request");
            end
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (outstanding != 0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                timed_out = 1'b1;
                $display("responses still missing after the last request");
            end
        end
    endtask

    initial begin
        void'($urandom(32'heb6d_1a55));
        resetn = 1'b1;
        valid = 1'b0;
        op = op_load;
        tag = '0;
        index = '0;
        offset = '0;
        wdata = '0;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        repeat (16) @(negedge clk);
        resetn = 1'b0;
        for (int n = 0; n < num_requests && !timed_out; n++) begin
            if ($urandom % 4 == 0) begin
                @(negedge clk);
            end
            send_request();
        end
        wait_for_drain();
        repeat (2) @(negedge clk);
        $display("done: %0d requests, %0d write-backs, %0d errors, %0d timeouts",
            num_requests, writebacks, error_count, int'(timed_out));
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // overall limit in case a wait loop itself stops advancing
    initial begin
        #2000000;
        $display("simulation ran past its time limit");
        $display("TEST FAIL");
        $finish;
    end

endmodule
